//--- verilog/core_settings.svh
/*
  execute/complete core widths and counts
*/
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// operand and result width
`define DATA_WIDTH 32

// physical destination tag width
`define TAG_WIDTH 6

// multiplier bits retired per step
`define MULT_BITS_PER_STEP 4

// step cycles for one full product
`define MULT_STEPS (`DATA_WIDTH / `MULT_BITS_PER_STEP)

// units contending for the completion bus
`define NUM_FU 3

`endif

//--- verilog/core_pkg.sv
/*
  core types for the execute/complete core
*/
`default_nettype none

`include "core_settings.svh"

package core_pkg;

  // operand / result word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // physical destination tag
  typedef logic [`TAG_WIDTH-1:0] tag_t;

  // multiplier step count, room for MULT_STEPS itself
  typedef logic [$clog2(`MULT_STEPS + 1)-1:0] step_t;

  // one-hot completion grant
  // bit 0 alu0, bit 1 alu1, bit 2 multiplier
  typedef logic [`NUM_FU-1:0] fu_grant_t;

  // unit id, doubles as grant bit index
  typedef enum logic [1:0] {
    fu_alu0 = 2'd0,
    fu_alu1 = 2'd1,
    fu_mult = 2'd2
  } fu_id_t;

  // alu opcodes, 3'd7 left unnamed as the illegal code
  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_sll  = 3'd5,
    op_halt = 3'd6
  } alu_op_t;

  typedef enum logic [1:0] {
    no_error          = 2'd0,
    halted_on_halt    = 2'd1,
    halted_on_illegal = 2'd2
  } error_t;

  // multiplier sequencer states
  typedef enum logic [1:0] {
    mult_idle = 2'd0,
    mult_run  = 2'd1,
    mult_hold = 2'd2
  } mult_state_t;

endpackage

`default_nettype wire

//--- verilog/alu_unit.sv
/*
  single-cycle alu with its execute-to-complete holding register
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module alu_unit (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    issue,
  input  wire core_pkg::alu_op_t op,
  input  wire core_pkg::data_t   operand_a,
  input  wire core_pkg::data_t   operand_b,
  input  wire core_pkg::tag_t    tag,
  input  wire                    grant,
  output logic                   ready,
  output logic                   held_valid,
  output core_pkg::tag_t         held_tag,
  output core_pkg::data_t        held_result,
  output core_pkg::error_t       held_error
);
  import core_pkg::*;

  // shift amount taken from the low bits of operand_b
  localparam int shift_bits = $clog2(`DATA_WIDTH);

  data_t  exec_result;
  error_t exec_error;
  logic   accept;

  //////////////////////////////
  // execute
  //////////////////////////////

  always_comb begin
    exec_result = '0;
    exec_error  = no_error;
    case (op)
      op_add:  exec_result = operand_a + operand_b;
      op_sub:  exec_result = operand_a - operand_b;
      op_and:  exec_result = operand_a & operand_b;
      op_or:   exec_result = operand_a | operand_b;
      op_xor:  exec_result = operand_a ^ operand_b;
      op_sll:  exec_result = operand_a << operand_b[shift_bits-1:0];
      // halt retires with a zero result
      op_halt: exec_error = halted_on_halt;
      // code 7 and anything unnamed
      default: exec_error = halted_on_illegal;
    endcase
  end

  //////////////////////////////
  // holding register
  //////////////////////////////

  // free when empty or draining this cycle
  assign ready  = ~held_valid | grant;
  assign accept = issue & ready;

  // refill on the grant edge keeps valid high
  always_ff @(posedge clock) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (grant) begin
      held_valid <= 1'b0;
    end
  end

  // payload only moves on an accepted issue
  always_ff @(posedge clock) begin
    if (accept) begin
      held_tag    <= tag;
      held_result <= exec_result;
      held_error  <= exec_error;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mult_sequencer.sv
/*
  multiplier control fsm, counts the steps and holds for the grant
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module mult_sequencer (
  input  wire  clock,
  input  wire  reset,
  input  wire  issue,
  input  wire  grant,
  output logic ready,
  output logic load,
  output logic step,
  output logic result_valid
);
  import core_pkg::*;

  mult_state_t state;
  mult_state_t state_next;
  step_t       step_count;
  logic        last_step;

  // only an idle multiplier takes new work
  assign ready        = (state == mult_idle);
  assign load         = issue & ready;
  assign step         = (state == mult_run);
  assign result_valid = (state == mult_hold);

  // final step lands on the MULT_STEPS-th run cycle
  assign last_step = step & (step_count == step_t'(`MULT_STEPS - 1));

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      mult_idle: if (load) state_next = mult_run;
      mult_run:  if (last_step) state_next = mult_hold;
      // wait out the completion bus
      mult_hold: if (grant) state_next = mult_idle;
      default:   state_next = mult_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mult_idle;
    end else begin
      state <= state_next;
    end
  end

  // step counter
  // restarts on every load
  always_ff @(posedge clock) begin
    if (reset || load) begin
      step_count <= '0;
    end else if (step) begin
      step_count <= step_count + step_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- verilog/mult_datapath.sv
/*
  iterative shift-add multiplier, MULT_BITS_PER_STEP multiplier bits a step
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module mult_datapath (
  input  wire                  clock,
  input  wire                  reset,
  input  wire                  load,
  input  wire                  step,
  input  wire core_pkg::data_t operand_a,
  input  wire core_pkg::data_t operand_b,
  input  wire core_pkg::tag_t  tag,
  output core_pkg::tag_t       held_tag,
  output core_pkg::data_t      held_result
);
  import core_pkg::*;

  data_t multiplicand;
  data_t multiplier;
  data_t accum;
  data_t partial;

  // multiplicand times the low multiplier digit
  // upper product bits fall off, only the low word is kept
  assign partial = multiplicand * data_t'(multiplier[`MULT_BITS_PER_STEP-1:0]);

  //////////////////////////////
  // operand shifters
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (load) begin
      multiplicand <= operand_a;
      multiplier   <= operand_b;
      held_tag     <= tag;
    end else if (step) begin
      // move to the next digit
      multiplicand <= multiplicand << `MULT_BITS_PER_STEP;
      multiplier   <= multiplier >> `MULT_BITS_PER_STEP;
    end
  end

  //////////////////////////////
  // accumulator
  //////////////////////////////

  // cleared per operation
  always_ff @(posedge clock) begin
    if (reset) begin
      accum <= '0;
    end else if (load) begin
      accum <= '0;
    end else if (step) begin
      accum <= accum + partial;
    end
  end

  // sits here through mult_hold until granted
  assign held_result = accum;

endmodule

`default_nettype wire

//--- verilog/complete_select.sv
/*
  fixed-priority completion select plus the complete/retire register
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module complete_select (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   alu0_valid,
  input  wire core_pkg::tag_t   alu0_tag,
  input  wire core_pkg::data_t  alu0_result,
  input  wire core_pkg::error_t alu0_error,
  input  wire                   alu1_valid,
  input  wire core_pkg::tag_t   alu1_tag,
  input  wire core_pkg::data_t  alu1_result,
  input  wire core_pkg::error_t alu1_error,
  input  wire                   mult_valid,
  input  wire core_pkg::tag_t   mult_tag,
  input  wire core_pkg::data_t  mult_result,
  output core_pkg::fu_grant_t   grant,
  output logic                  commit_valid,
  output core_pkg::tag_t        commit_tag,
  output core_pkg::data_t       commit_result,
  output core_pkg::fu_id_t      commit_unit,
  output core_pkg::error_t      error_status
);
  import core_pkg::*;

  fu_grant_t req;
  logic      sel_valid;
  tag_t      sel_tag;
  data_t     sel_result;
  fu_id_t    sel_unit;
  error_t    sel_error;

  //////////////////////////////
  // grant
  //////////////////////////////

  // request bits in unit id order
  assign req = {mult_valid, alu1_valid, alu0_valid};

  // keep only the lowest set request bit
  // alu0 beats alu1 beats the multiplier
  assign grant = req & (~req + fu_grant_t'(1));

  assign sel_valid = |grant;

  // mux of the granted entry
  // idle bus selects zeros and no_error
  always_comb begin
    sel_tag    = '0;
    sel_result = '0;
    sel_unit   = fu_alu0;
    sel_error  = no_error;
    if (grant[fu_alu0]) begin
      sel_tag    = alu0_tag;
      sel_result = alu0_result;
      sel_error  = alu0_error;
    end else if (grant[fu_alu1]) begin
      sel_tag    = alu1_tag;
      sel_result = alu1_result;
      sel_unit   = fu_alu1;
      sel_error  = alu1_error;
    end else if (grant[fu_mult]) begin
      // products never flag an error
      sel_tag    = mult_tag;
      sel_result = mult_result;
      sel_unit   = fu_mult;
    end
  end

  //////////////////////////////
  // complete/retire register
  //////////////////////////////

  // always enabled
  // commit_valid is a one-cycle pulse per grant
  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      error_status <= no_error;
    end else begin
      commit_valid <= sel_valid;
      error_status <= sel_error;
    end
  end

  always_ff @(posedge clock) begin
    commit_tag    <= sel_tag;
    commit_result <= sel_result;
    commit_unit   <= sel_unit;
  end

endmodule

`default_nettype wire

//--- verilog/fu_complete_core.sv
/*
  execute/complete core with two alus, one multiplier and the completion stage
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module fu_complete_core (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    alu0_issue,
  input  wire core_pkg::alu_op_t alu0_op,
  input  wire core_pkg::data_t   alu0_a,
  input  wire core_pkg::data_t   alu0_b,
  input  wire core_pkg::tag_t    alu0_tag,
  input  wire                    alu1_issue,
  input  wire core_pkg::alu_op_t alu1_op,
  input  wire core_pkg::data_t   alu1_a,
  input  wire core_pkg::data_t   alu1_b,
  input  wire core_pkg::tag_t    alu1_tag,
  input  wire                    mult_issue,
  input  wire core_pkg::data_t   mult_a,
  input  wire core_pkg::data_t   mult_b,
  input  wire core_pkg::tag_t    mult_tag,
  output logic                   alu0_ready,
  output logic                   alu1_ready,
  output logic                   mult_ready,
  output logic                   commit_valid,
  output core_pkg::tag_t         commit_tag,
  output core_pkg::data_t        commit_result,
  output core_pkg::fu_id_t       commit_unit,
  output core_pkg::error_t       error_status
);
  import core_pkg::*;

  // held entries toward completion
  logic      alu0_held_valid;
  tag_t      alu0_held_tag;
  data_t     alu0_held_result;
  error_t    alu0_held_error;
  logic      alu1_held_valid;
  tag_t      alu1_held_tag;
  data_t     alu1_held_result;
  error_t    alu1_held_error;
  logic      mult_held_valid;
  tag_t      mult_held_tag;
  data_t     mult_held_result;

  // sequencer to datapath
  logic      mult_load;
  logic      mult_step;

  // completion grant and its per-unit bits
  fu_grant_t grant;
  logic      alu0_grant;
  logic      alu1_grant;
  logic      mult_grant;

  assign alu0_grant = grant[fu_alu0];
  assign alu1_grant = grant[fu_alu1];
  assign mult_grant = grant[fu_mult];

  //////////////////////////////
  // execute
  //////////////////////////////

  alu_unit i_alu0 (
    .clock       (clock),
    .reset       (reset),
    .issue       (alu0_issue),
    .op          (alu0_op),
    .operand_a   (alu0_a),
    .operand_b   (alu0_b),
    .tag         (alu0_tag),
    .grant       (alu0_grant),
    .ready       (alu0_ready),
    .held_valid  (alu0_held_valid),
    .held_tag    (alu0_held_tag),
    .held_result (alu0_held_result),
    .held_error  (alu0_held_error)
  );

  alu_unit i_alu1 (
    .clock       (clock),
    .reset       (reset),
    .issue       (alu1_issue),
    .op          (alu1_op),
    .operand_a   (alu1_a),
    .operand_b   (alu1_b),
    .tag         (alu1_tag),
    .grant       (alu1_grant),
    .ready       (alu1_ready),
    .held_valid  (alu1_held_valid),
    .held_tag    (alu1_held_tag),
    .held_result (alu1_held_result),
    .held_error  (alu1_held_error)
  );

  // multiplier control
  mult_sequencer i_mult_sequencer (
    .clock        (clock),
    .reset        (reset),
    .issue        (mult_issue),
    .grant        (mult_grant),
    .ready        (mult_ready),
    .load         (mult_load),
    .step         (mult_step),
    .result_valid (mult_held_valid)
  );

  mult_datapath i_mult_datapath (
    .clock       (clock),
    .reset       (reset),
    .load        (mult_load),
    .step        (mult_step),
    .operand_a   (mult_a),
    .operand_b   (mult_b),
    .tag         (mult_tag),
    .held_tag    (mult_held_tag),
    .held_result (mult_held_result)
  );

  //////////////////////////////
  // complete
  //////////////////////////////

  complete_select i_complete_select (
    .clock         (clock),
    .reset         (reset),
    .alu0_valid    (alu0_held_valid),
    .alu0_tag      (alu0_held_tag),
    .alu0_result   (alu0_held_result),
    .alu0_error    (alu0_held_error),
    .alu1_valid    (alu1_held_valid),
    .alu1_tag      (alu1_held_tag),
    .alu1_result   (alu1_held_result),
    .alu1_error    (alu1_held_error),
    .mult_valid    (mult_held_valid),
    .mult_tag      (mult_held_tag),
    .mult_result   (mult_held_result),
    .grant         (grant),
    .commit_valid  (commit_valid),
    .commit_tag    (commit_tag),
    .commit_result (commit_result),
    .commit_unit   (commit_unit),
    .error_status  (error_status)
  );

endmodule

`default_nettype wire

//--- dv/core_tb.sv
/*
  testbench for the execute/complete core
  lfsr stimulus on all three units, per-unit expected queues, watchdog
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module core_tb;
  import core_pkg::*;

  // queue entry is {error, tag, result}
  localparam int entry_w = 2 + `TAG_WIDTH + `DATA_WIDTH;
  localparam int rand_cycles = 400;
  localparam int sustain_cycles = 40;
  localparam int max_issues = 3 * rand_cycles + sustain_cycles + 16;
  // ns, scaled from the worst case per issue
  localparam int watchdog_ns = max_issues * (`MULT_STEPS + 4) * 20 + 2000;

  logic    clock;
  logic    reset;
  logic    alu0_issue;
  alu_op_t alu0_op;
  data_t   alu0_a;
  data_t   alu0_b;
  tag_t    alu0_tag;
  logic    alu1_issue;
  alu_op_t alu1_op;
  data_t   alu1_a;
  data_t   alu1_b;
  tag_t    alu1_tag;
  logic    mult_issue;
  data_t   mult_a;
  data_t   mult_b;
  tag_t    mult_tag;
  logic    alu0_ready;
  logic    alu1_ready;
  logic    mult_ready;
  logic    commit_valid;
  tag_t    commit_tag;
  data_t   commit_result;
  fu_id_t  commit_unit;
  error_t  error_status;

  // expected results in issue order, one queue per unit
  logic [entry_w-1:0] alu0_q[$];
  logic [entry_w-1:0] alu1_q[$];
  logic [entry_w-1:0] mult_q[$];

  // accept seen at the last falling edge
  bit alu0_taken;
  bit alu1_taken;
  bit mult_taken;

  logic [15:0] lfsr_state;
  int errors;
  int tests;
  int commits;
  int mult_commits;

  fu_complete_core i_fu_complete_core (
    .clock         (clock),
    .reset         (reset),
    .alu0_issue    (alu0_issue),
    .alu0_op       (alu0_op),
    .alu0_a        (alu0_a),
    .alu0_b        (alu0_b),
    .alu0_tag      (alu0_tag),
    .alu1_issue    (alu1_issue),
    .alu1_op       (alu1_op),
    .alu1_a        (alu1_a),
    .alu1_b        (alu1_b),
    .alu1_tag      (alu1_tag),
    .mult_issue    (mult_issue),
    .mult_a        (mult_a),
    .mult_b        (mult_b),
    .mult_tag      (mult_tag),
    .alu0_ready    (alu0_ready),
    .alu1_ready    (alu1_ready),
    .mult_ready    (mult_ready),
    .commit_valid  (commit_valid),
    .commit_tag    (commit_tag),
    .commit_result (commit_result),
    .commit_unit   (commit_unit),
    .error_status  (error_status)
  );

  // 20 ns period
  always #10 clock = ~clock;

  //////////////////////////////
  // random source
  //////////////////////////////

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [entry_w-1:0] alu_expect(input logic [2:0] code, input data_t a,
                                                    input data_t b, input tag_t t);
    data_t  res;
    error_t err;
    res = '0;
    err = no_error;
    case (code)
      3'd0: res = a + b;
      3'd1: res = a - b;
      3'd2: res = a & b;
      3'd3: res = a | b;
      3'd4: res = a ^ b;
      // shift amount is b[4:0]
      3'd5: res = a << b[4:0];
      3'd6: err = halted_on_halt;
      default: err = halted_on_illegal;
    endcase
    return {err, t, res};
  endfunction

  // only the low word of the product survives
  function automatic logic [entry_w-1:0] mult_expect(input data_t a, input data_t b,
                                                     input tag_t t);
    data_t p;
    p = a * b;
    return {no_error, t, p};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  // pop the committing unit's queue and compare
  task automatic check_commit();
    logic [entry_w-1:0] exp;
    bit found;
    found = 1'b1;
    exp = '0;
    case (commit_unit)
      fu_alu0: if (alu0_q.size() > 0) exp = alu0_q.pop_front(); else found = 1'b0;
      fu_alu1: if (alu1_q.size() > 0) exp = alu1_q.pop_front(); else found = 1'b0;
      fu_mult: begin
        if (mult_q.size() > 0) exp = mult_q.pop_front(); else found = 1'b0;
        mult_commits++;
      end
      default: found = 1'b0;
    endcase
    commits++;
    if (!found) begin
      report_failure($sformatf("commit from unit %0d arrived with no result outstanding",
                               commit_unit));
    end else begin
      if (commit_tag !== exp[`DATA_WIDTH +: `TAG_WIDTH])
        report_mismatch($sformatf("unit %0d tag %0d, expected %0d", commit_unit,
                                  commit_tag, exp[`DATA_WIDTH +: `TAG_WIDTH]));
      if (commit_result !== exp[`DATA_WIDTH-1:0])
        report_mismatch($sformatf("unit %0d result %h, expected %h", commit_unit,
                                  commit_result, exp[`DATA_WIDTH-1:0]));
      if (error_status !== exp[entry_w-1 -: 2])
        report_mismatch($sformatf("unit %0d error %0d, expected %0d", commit_unit,
                                  error_status, exp[entry_w-1 -: 2]));
    end
  endtask

  // accepts and commits, sampled mid-cycle where everything is settled
  always @(negedge clock) begin
    if (!reset) begin
      alu0_taken = alu0_issue && alu0_ready;
      alu1_taken = alu1_issue && alu1_ready;
      mult_taken = mult_issue && mult_ready;
      if (alu0_taken) alu0_q.push_back(alu_expect(alu0_op, alu0_a, alu0_b, alu0_tag));
      if (alu1_taken) alu1_q.push_back(alu_expect(alu1_op, alu1_a, alu1_b, alu1_tag));
      if (mult_taken) mult_q.push_back(mult_expect(mult_a, mult_b, mult_tag));
      if (commit_valid) check_commit();
    end
  end

  //////////////////////////////
  // drivers
  //////////////////////////////

  task automatic drive_alu(input int unit, input alu_op_t op, input data_t a, input data_t b,
                           input tag_t t);
    if (unit == 0) begin
      alu0_issue <= 1'b1;
      alu0_op    <= op;
      alu0_a     <= a;
      alu0_b     <= b;
      alu0_tag   <= t;
    end else begin
      alu1_issue <= 1'b1;
      alu1_op    <= op;
      alu1_a     <= a;
      alu1_b     <= b;
      alu1_tag   <= t;
    end
  endtask

  task automatic drive_mult(input data_t a, input data_t b, input tag_t t);
    mult_issue <= 1'b1;
    mult_a     <= a;
    mult_b     <= b;
    mult_tag   <= t;
  endtask

  task automatic drive_random_alu(input int unit);
    alu_op_t op;
    data_t   a;
    data_t   b;
    tag_t    t;
    op = alu_op_t'(random_bits(3));
    a = random_bits(32);
    b = random_bits(32);
    t = tag_t'(random_bits(`TAG_WIDTH));
    drive_alu(unit, op, a, b, t);
  endtask

  task automatic drive_random_mult();
    data_t a;
    data_t b;
    tag_t  t;
    a = random_bits(32);
    b = random_bits(32);
    t = tag_t'(random_bits(`TAG_WIDTH));
    drive_mult(a, b, t);
  endtask

  // one rising edge, weights in sixteenths
  // a pending issue stays up until it is taken
  task automatic drive_cycle(input int w0, input int w1, input int wm);
    @(posedge clock);
    if (!alu0_issue || alu0_taken) begin
      if (random_bits(4) < w0) drive_random_alu(0);
      else alu0_issue <= 1'b0;
    end
    if (!alu1_issue || alu1_taken) begin
      if (random_bits(4) < w1) drive_random_alu(1);
      else alu1_issue <= 1'b0;
    end
    if (!mult_issue || mult_taken) begin
      if (random_bits(4) < wm) drive_random_mult();
      else mult_issue <= 1'b0;
    end
  endtask

  task automatic idle_inputs();
    @(posedge clock);
    alu0_issue <= 1'b0;
    alu1_issue <= 1'b0;
    mult_issue <= 1'b0;
  endtask

  // falling edges until commit_valid, optionally watching mult_ready
  task automatic wait_commit(input int limit, input bit mult_busy, output int cycles);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (mult_busy && !commit_valid && mult_ready)
        report_mismatch($sformatf("mult_ready high %0d cycles after issue", cycles));
    end while (!commit_valid && cycles < limit);
    if (!commit_valid) report_failure($sformatf("no commit within %0d cycles", limit));
  endtask

  // isolated alu issue, returns the commit latency
  task automatic single_alu(input int unit, input alu_op_t op, input data_t a, input data_t b,
                            input tag_t t, output int cycles);
    @(posedge clock);
    drive_alu(unit, op, a, b, t);
    @(posedge clock);
    alu0_issue <= 1'b0;
    alu1_issue <= 1'b0;
    wait_commit(`MULT_STEPS + 6, 1'b0, cycles);
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    while (alu0_q.size() + alu1_q.size() + mult_q.size() != 0 && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (alu0_q.size() + alu1_q.size() + mult_q.size() != 0)
      report_failure($sformatf("results never committed: %0d alu0, %0d alu1, %0d mult",
                               alu0_q.size(), alu1_q.size(), mult_q.size()));
  endtask

  task automatic finish_test(input int num, input string name, input int start_errors);
    tests++;
    $display("test %0d %s: %0d errors", num, name, errors - start_errors);
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int start;
    int n;
    int base;
    clock = 1'b0;
    reset = 1'b1;
    alu0_issue = 1'b0;
    alu0_op = op_add;
    alu0_a = '0;
    alu0_b = '0;
    alu0_tag = '0;
    alu1_issue = 1'b0;
    alu1_op = op_add;
    alu1_a = '0;
    alu1_b = '0;
    alu1_tag = '0;
    mult_issue = 1'b0;
    mult_a = '0;
    mult_b = '0;
    mult_tag = '0;
    lfsr_state = 16'd91;
    errors = 0;
    tests = 0;
    commits = 0;
    mult_commits = 0;

    // reset state
    start = errors;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    if (commit_valid !== 1'b0) report_mismatch("commit_valid high after reset");
    if (error_status !== no_error) report_mismatch("error_status set after reset");
    if (alu0_ready !== 1'b1 || alu1_ready !== 1'b1 || mult_ready !== 1'b1)
      report_mismatch("a unit is not ready after reset");
    finish_test(1, "reset state", start);

    // isolated latencies
    start = errors;
    single_alu(0, op_add, 32'h1234_5678, 32'h0000_1111, 6'd5, n);
    if (n != 2) report_mismatch($sformatf("alu latency %0d, expected 2", n));
    @(posedge clock);
    drive_mult(32'hdead_beef, 32'h1234_5679, 6'd9);
    @(posedge clock);
    mult_issue <= 1'b0;
    wait_commit(`MULT_STEPS + 6, 1'b1, n);
    if (n != `MULT_STEPS + 2)
      report_mismatch($sformatf("mult latency %0d, expected %0d", n, `MULT_STEPS + 2));
    if (commit_unit !== fu_mult) report_mismatch("isolated multiply not from the multiplier");
    finish_test(2, "isolated latency", start);

    // same-edge alu issue, alu0 wins
    start = errors;
    @(posedge clock);
    drive_alu(0, op_xor, 32'hf0f0_0f0f, 32'h0ff0_ff00, 6'd12);
    drive_alu(1, op_sub, 32'h0000_0010, 32'h0000_0020, 6'd13);
    @(posedge clock);
    alu0_issue <= 1'b0;
    alu1_issue <= 1'b0;
    @(negedge clock);
    if (commit_valid) report_mismatch("commit one cycle early");
    if (alu1_ready) report_mismatch("alu1_ready high while alu1 waits");
    @(negedge clock);
    if (!commit_valid || commit_unit !== fu_alu0) report_mismatch("alu0 did not commit first");
    @(negedge clock);
    if (!commit_valid || commit_unit !== fu_alu1) report_mismatch("alu1 did not commit next");
    finish_test(3, "alu contention", start);

    // mixed random stream
    start = errors;
    repeat (rand_cycles) drive_cycle(8, 8, 5);
    idle_inputs();
    drain(200);
    finish_test(4, "random mixed stream", start);

    // halt and illegal codes
    start = errors;
    single_alu(0, op_halt, 32'hffff_ffff, 32'h0000_0001, 6'd20, n);
    if (commit_result !== '0 || error_status !== halted_on_halt)
      report_mismatch("halt did not commit zero with halted_on_halt");
    single_alu(1, alu_op_t'(3'd7), 32'h1357_9bdf, 32'h2468_ace0, 6'd21, n);
    if (commit_result !== '0 || error_status !== halted_on_illegal)
      report_mismatch("illegal code did not commit zero with halted_on_illegal");
    single_alu(1, op_or, 32'h0000_00f0, 32'h0000_000f, 6'd22, n);
    if (error_status !== no_error) report_mismatch("error_status set on a plain op");
    finish_test(5, "halt and illegal", start);

    // multiplier starved by alu0
    start = errors;
    base = mult_commits;
    @(posedge clock);
    drive_mult(32'h0001_0003, 32'h8000_0005, 6'd33);
    for (int i = 0; i < sustain_cycles; i++) begin
      drive_cycle(16, 0, 0);
      @(negedge clock);
      if (mult_ready) report_mismatch("mult_ready high while its result waits");
      if (commit_valid && commit_unit === fu_mult)
        report_mismatch("multiplier committed under alu0 traffic");
    end
    idle_inputs();
    drain(50);
    if (mult_commits != base + 1)
      report_failure("the held product did not commit once alu0 went quiet");
    finish_test(6, "multiplier back-pressure", start);

    $display("%0d tests, %0d commits checked, %0d errors", tests, commits, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/core_pkg.sv
verilog/alu_unit.sv
verilog/mult_sequencer.sv
verilog/mult_datapath.sv
verilog/complete_select.sv
verilog/fu_complete_core.sv
dv/core_tb.sv

//--- Bender.yml
package:
  name: fu_complete_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/alu_unit.sv
      - verilog/mult_sequencer.sv
      - verilog/mult_datapath.sv
      - verilog/complete_select.sv
      - verilog/fu_complete_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/core_tb.sv
